/* rtr_pkg.sv */
// router shared definitions
`default_nettype none

package rtr_pkg;

   // --------------------
   // port numbering
   // --------------------

   // local, left and right
   localparam int NUM_PORTS = 3;

   // enough bits to name any port
   localparam int PORT_W = 2;

   // the node attached to this router
   localparam logic [PORT_W-1:0] PORT_LOCAL = 2'd0;
   // toward lower addresses
   localparam logic [PORT_W-1:0] PORT_LEFT = 2'd1;
   // toward higher addresses
   localparam logic [PORT_W-1:0] PORT_RIGHT = 2'd2;

   // --------------------
   // flit format
   // --------------------

   // four routers on the line
   localparam int ADDR_W = 2;

   // data word carried by every flit
   localparam int DATA_W = 16;

   // what is left of a head word after the address
   localparam int PAYLOAD_W = DATA_W - ADDR_W;

   // --------------------
   // flow control
   // --------------------

   // flits per input buffer, also the starting credit of each output
   localparam int BUF_DEPTH = 4;

   // must hold 0 .. BUF_DEPTH
   localparam int CREDIT_W = 3;

   // head flits carry the destination on top, body flits are plain data
   typedef union packed {
      logic [DATA_W-1:0] body;
      struct packed {
         logic [ADDR_W-1:0]    dest;
         logic [PAYLOAD_W-1:0] payload;
      } head;
   } flit_data_u;

endpackage

`default_nettype wire

/* rtr_input_buffer.sv */
// input flit buffer
`default_nettype none

module rtr_input_buffer
   import rtr_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   // own position on the line
   input  logic [ADDR_W-1:0] router_address,
   // incoming link
   input  logic              flit_valid_in,
   input  logic              flit_head_in,
   input  logic              flit_tail_in,
   input  flit_data_u        flit_data_in,
   // front flit has been taken
   input  logic              pop,
   // front of queue, seen by allocator and crossbar
   output logic              front_valid,
   output logic              front_head,
   output logic              front_tail,
   output flit_data_u        front_data,
   output logic [PORT_W-1:0] front_port,
   // one slot freed upstream
   output logic              credit_out,
   output logic              overflow_err
);

   // flit storage, split by field
   logic       head_mem [BUF_DEPTH];
   logic       tail_mem [BUF_DEPTH];
   flit_data_u data_mem [BUF_DEPTH];

   // depth is a power of two, pointers wrap on their own
   logic [$clog2(BUF_DEPTH)-1:0] wr_ptr;
   logic [$clog2(BUF_DEPTH)-1:0] rd_ptr;
   logic [CREDIT_W-1:0]          count;
   logic                         full;
   logic                         wr_en;

   assign full  = (count == CREDIT_W'(BUF_DEPTH));
   // a flit arriving at a full buffer is lost
   assign wr_en        = flit_valid_in && !full;
   assign overflow_err = flit_valid_in && full;

   // --------------------
   // storage
   // --------------------

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         head_mem[wr_ptr] <= flit_head_in;
         tail_mem[wr_ptr] <= flit_tail_in;
         data_mem[wr_ptr] <= flit_data_in;
      end
   end

   // pointers, occupancy and credit return
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         credit_out <= 1'b0;
      end
      else
      begin
         if (wr_en)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // slot is free once the flit has left
         credit_out <= pop;
      end
   end

   // --------------------
   // front flit and route
   // --------------------

   assign front_valid = (count != '0);
   assign front_head  = head_mem[rd_ptr];
   assign front_tail  = tail_mem[rd_ptr];
   assign front_data  = data_mem[rd_ptr];

   // dimension order on a line, only meaningful for a head flit
   always_comb
   begin
      if (front_data.head.dest < router_address)
      begin
         front_port = PORT_LEFT;
      end
      else if (front_data.head.dest > router_address)
      begin
         front_port = PORT_RIGHT;
      end
      else
      begin
         front_port = PORT_LOCAL;
      end
   end

endmodule

`default_nettype wire

/* rtr_credit_counter.sv */
// output credit counter
`default_nettype none

module rtr_credit_counter
   import rtr_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   // a flit leaves on this output
   input  logic send,
   // downstream freed a slot
   input  logic credit_in,
   // at least one slot free downstream
   output logic credit_avail,
   // credit returned with nothing outstanding
   output logic overflow_err
);

   // free slots in the downstream buffer
   logic [CREDIT_W-1:0] count;
   logic                at_max;

   assign at_max = (count == CREDIT_W'(BUF_DEPTH));

   // a send in the same cycle uses up the slot, so no overflow then
   assign overflow_err = credit_in && !send && at_max;

   assign credit_avail = (count != '0);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         // downstream buffer starts empty
         count <= CREDIT_W'(BUF_DEPTH);
      end
      else
      begin
         case ({send, credit_in})
            2'b10:   count <= count - 1'b1;
            // excess credits are ignored, they only raise the error
            2'b01:   count <= at_max ? count : count + 1'b1;
            // send and return together cancel out
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtr_switch_alloc.sv */
// wormhole switch allocator
`default_nettype none

module rtr_switch_alloc
   import rtr_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst_n,
   // front flit of each input
   input  logic [NUM_PORTS-1:0]             front_valid,
   input  logic [NUM_PORTS-1:0]             front_head,
   input  logic [NUM_PORTS-1:0]             front_tail,
   input  logic [NUM_PORTS-1:0][PORT_W-1:0] front_port,
   // per output
   input  logic [NUM_PORTS-1:0]             credit_avail,
   // per input, front flit consumed
   output logic [NUM_PORTS-1:0]             pop,
   // per output, flit goes out this cycle from input sel_in
   output logic [NUM_PORTS-1:0]             send,
   output logic [NUM_PORTS-1:0][PORT_W-1:0] sel_in,
   output logic                             framing_err
);

   // per output: packet in progress, its input, next input to favour
   logic [NUM_PORTS-1:0]             active;
   logic [NUM_PORTS-1:0][PORT_W-1:0] owner;
   logic [NUM_PORTS-1:0][PORT_W-1:0] rr_ptr;
   // per input: some output is carrying its packet
   logic [NUM_PORTS-1:0]             owned;
   // body or tail flit with no packet around it
   logic [NUM_PORTS-1:0]             orphan;
   // idle arbitration result per output
   logic [NUM_PORTS-1:0]             grant;
   logic [NUM_PORTS-1:0][PORT_W-1:0] winner;

   always_comb
   begin
      owned = '0;
      for (int o = 0; o < NUM_PORTS; o++)
      begin
         if (active[o])
         begin
            owned[owner[o]] = 1'b1;
         end
      end
   end

   // --------------------
   // round robin
   // --------------------

   // owned inputs are skipped so no input ever has two outputs
   always_comb
   begin
      int idx;
      grant  = '0;
      winner = '0;
      for (int o = 0; o < NUM_PORTS; o++)
      begin
         for (int k = 0; k < NUM_PORTS; k++)
         begin
            idx = (int'(rr_ptr[o]) + k) % NUM_PORTS;
            if (!grant[o] && front_valid[idx] && front_head[idx] && !owned[idx]
                && (front_port[idx] == PORT_W'(o)))
            begin
               grant[o]  = 1'b1;
               winner[o] = PORT_W'(idx);
            end
         end
      end
   end

   // head goes out in the grant cycle when a credit is there
   always_comb
   begin
      for (int o = 0; o < NUM_PORTS; o++)
      begin
         if (active[o])
         begin
            sel_in[o] = owner[o];
            send[o]   = front_valid[owner[o]] && credit_avail[o];
         end
         else
         begin
            sel_in[o] = winner[o];
            send[o]   = grant[o] && credit_avail[o];
         end
      end
   end

   // orphan flits are dropped so the input does not lock up
   assign orphan      = front_valid & ~front_head & ~owned;
   assign framing_err = |orphan;

   always_comb
   begin
      pop = orphan;
      for (int o = 0; o < NUM_PORTS; o++)
      begin
         if (send[o])
         begin
            pop[sel_in[o]] = 1'b1;
         end
      end
   end

   // --------------------
   // ownership FSM
   // --------------------

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         active <= '0;
         owner  <= '0;
         rr_ptr <= {NUM_PORTS{PORT_LOCAL}};
      end
      else
      begin
         for (int o = 0; o < NUM_PORTS; o++)
         begin
            if (!active[o] && grant[o])
            begin
               // ownership holds even if the head waits for a credit
               owner[o]  <= winner[o];
               rr_ptr[o] <= (winner[o] == PORT_W'(NUM_PORTS - 1)) ? PORT_LOCAL
                                                                 : winner[o] + 1'b1;
               // single-flit packet done at once
               active[o] <= !(send[o] && front_tail[winner[o]]);
            end
            else if (active[o] && send[o] && front_tail[owner[o]])
            begin
               active[o] <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* rtr_top.sv */
// line network router
`default_nettype none

module rtr_top
   import rtr_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [ADDR_W-1:0]                router_address,
   // incoming links, one per port
   input  logic [NUM_PORTS-1:0]             flit_valid_in,
   input  logic [NUM_PORTS-1:0]             flit_head_in,
   input  logic [NUM_PORTS-1:0]             flit_tail_in,
   input  logic [NUM_PORTS-1:0][DATA_W-1:0] flit_data_in,
   // credits from downstream, per output
   input  logic [NUM_PORTS-1:0]             credit_in,
   // outgoing links
   output logic [NUM_PORTS-1:0]             flit_valid_out,
   output logic [NUM_PORTS-1:0]             flit_head_out,
   output logic [NUM_PORTS-1:0]             flit_tail_out,
   output logic [NUM_PORTS-1:0][DATA_W-1:0] flit_data_out,
   // credits to upstream, per input
   output logic [NUM_PORTS-1:0]             credit_out,
   output logic                             error
);

   // buffer fronts
   logic [NUM_PORTS-1:0]             front_valid;
   logic [NUM_PORTS-1:0]             front_head;
   logic [NUM_PORTS-1:0]             front_tail;
   flit_data_u [NUM_PORTS-1:0]       front_data;
   logic [NUM_PORTS-1:0][PORT_W-1:0] front_port;
   // allocator decisions
   logic [NUM_PORTS-1:0]             pop;
   logic [NUM_PORTS-1:0]             send;
   logic [NUM_PORTS-1:0][PORT_W-1:0] sel_in;
   logic [NUM_PORTS-1:0]             credit_avail;
   // crossbar outputs
   logic [NUM_PORTS-1:0]             xbar_head;
   logic [NUM_PORTS-1:0]             xbar_tail;
   logic [NUM_PORTS-1:0][DATA_W-1:0] xbar_data;
   // error sources
   logic [NUM_PORTS-1:0]             buf_overflow;
   logic [NUM_PORTS-1:0]             cc_overflow;
   logic                             framing_err;
   logic                             error_d;

   // --------------------
   // per-port blocks
   // --------------------

   for (genvar p = 0; p < NUM_PORTS; p++)
   begin : g_port
      rtr_input_buffer u_ibuf (
         .clk            (clk),
         .rst_n          (rst_n),
         .router_address (router_address),
         .flit_valid_in  (flit_valid_in[p]),
         .flit_head_in   (flit_head_in[p]),
         .flit_tail_in   (flit_tail_in[p]),
         .flit_data_in   (flit_data_in[p]),
         .pop            (pop[p]),
         .front_valid    (front_valid[p]),
         .front_head     (front_head[p]),
         .front_tail     (front_tail[p]),
         .front_data     (front_data[p]),
         .front_port     (front_port[p]),
         .credit_out     (credit_out[p]),
         .overflow_err   (buf_overflow[p])
      );

      // tracks free slots of the router on this output
      rtr_credit_counter u_ccnt (
         .clk          (clk),
         .rst_n        (rst_n),
         .send         (send[p]),
         .credit_in    (credit_in[p]),
         .credit_avail (credit_avail[p]),
         .overflow_err (cc_overflow[p])
      );
   end

   rtr_switch_alloc u_alloc (
      .clk          (clk),
      .rst_n        (rst_n),
      .front_valid  (front_valid),
      .front_head   (front_head),
      .front_tail   (front_tail),
      .front_port   (front_port),
      .credit_avail (credit_avail),
      .pop          (pop),
      .send         (send),
      .sel_in       (sel_in),
      .framing_err  (framing_err)
   );

   // --------------------
   // crossbar
   // --------------------

   always_comb
   begin
      for (int o = 0; o < NUM_PORTS; o++)
      begin
         xbar_head[o] = front_head[sel_in[o]];
         xbar_tail[o] = front_tail[sel_in[o]];
         xbar_data[o] = front_data[sel_in[o]].body;
      end
   end

   // output register, valid follows send every cycle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         flit_valid_out <= '0;
      end
      else
      begin
         flit_valid_out <= send;
      end
   end

   always_ff @(posedge clk)
   begin
      for (int o = 0; o < NUM_PORTS; o++)
      begin
         if (send[o])
         begin
            flit_head_out[o] <= xbar_head[o];
            flit_tail_out[o] <= xbar_tail[o];
            flit_data_out[o] <= xbar_data[o];
         end
      end
   end

   // --------------------
   // error report
   // --------------------

   // no hold, one pulse per event
   assign error_d = |{buf_overflow, cc_overflow, framing_err};

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         error <= 1'b0;
      end
      else
      begin
         error <= error_d;
      end
   end

endmodule

`default_nettype wire

/* tb_clock.sv */
// testbench clock and reset
`default_nettype none

module tb_clock
(
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int PERIOD       = 20;
   localparam int RESET_CYCLES = 3;

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(PERIOD / 2) clk = ~clk;
      end
   end

   // release on a falling edge, away from the sampling edge
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* rtr_sva.sv */
// router protocol checks
`default_nettype none

module rtr_sva
   import rtr_pkg::*;
(
   input logic                 clk,
   input logic                 rst_n,
   input logic [NUM_PORTS-1:0] flit_valid_in,
   input logic [NUM_PORTS-1:0] flit_valid_out,
   input logic [NUM_PORTS-1:0] flit_head_out,
   input logic [NUM_PORTS-1:0] flit_tail_out,
   input logic [NUM_PORTS-1:0] credit_out,
   input logic                 error
);
   timeunit 1ns;
   timeprecision 1ps;

   // read by the testbench at the end of the run
   int fail_count = 0;

   // per output: a head went out and its tail has not yet
   logic [NUM_PORTS-1:0] in_pkt;

   // per input: flits taken in whose credit has not come back
   // dropped flits count too, so this is an upper bound
   int held [NUM_PORTS];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         in_pkt <= '0;
      end
      else
      begin
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            if (flit_valid_out[p])
            begin
               in_pkt[p] <= !flit_tail_out[p];
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            held[p] <= 0;
         end
      end
      else
      begin
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            held[p] <= held[p] + int'(flit_valid_in[p]) - int'(credit_out[p]);
         end
      end
   end

   // --------------------
   // properties
   // --------------------

   // nothing is reported in the first cycle out of reset
   error_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !error)
   else
   begin
      $error("error high in the first cycle after reset");
      fail_count++;
   end

   for (genvar p = 0; p < NUM_PORTS; p++)
   begin : g_port
      // wormhole framing on each output link
      head_inside_packet: assert property (@(posedge clk) disable iff (!rst_n)
         flit_valid_out[p] && flit_head_out[p] |-> !in_pkt[p])
      else
      begin
         $error("output %0d sent a head before the previous tail", p);
         fail_count++;
      end

      // one pulse per flit, a stretched pulse runs the count dry
      credit_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
         credit_out[p] |-> held[p] > 0)
      else
      begin
         $error("credit_out of input %0d pulsed with no flit left to return", p);
         fail_count++;
      end
   end

endmodule

`default_nettype wire

/* rtr_tb.sv */
// router directed testbench
`default_nettype none

module rtr_tb
   import rtr_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int ROUTER_ADDR = 1;
   localparam int TIMEOUT     = 200;
   localparam int LEN_A       = 4;
   localparam int LEN_B       = 5;
   localparam int BP_LEN      = 6;
   localparam int RAND_ROUNDS = 12;

   logic                             clk;
   logic                             rst_n;
   logic [NUM_PORTS-1:0]             flit_valid_in;
   logic [NUM_PORTS-1:0]             flit_head_in;
   logic [NUM_PORTS-1:0]             flit_tail_in;
   logic [NUM_PORTS-1:0][DATA_W-1:0] flit_data_in;
   logic [NUM_PORTS-1:0]             credit_in;
   logic [NUM_PORTS-1:0]             flit_valid_out;
   logic [NUM_PORTS-1:0]             flit_head_out;
   logic [NUM_PORTS-1:0]             flit_tail_out;
   logic [NUM_PORTS-1:0][DATA_W-1:0] flit_data_out;
   logic [NUM_PORTS-1:0]             credit_out;
   logic                             error;

   // upstream side: own credits, flits accepted, credit_out pulses seen
   int tb_credit [NUM_PORTS];
   int accepted  [NUM_PORTS];
   int returned  [NUM_PORTS];
   // downstream side: credits not yet handed back
   int                   owed [NUM_PORTS];
   logic [NUM_PORTS-1:0] hold_credit;
   // received flits as {port, head, tail, data}
   logic [PORT_W+DATA_W+1:0] rx_q [$];
   // model of the allocator's round-robin pointer per output
   logic [PORT_W-1:0] rr_next [NUM_PORTS];
   logic              err_allowed;
   int                err_seen;
   int                seed;

   tb_clock u_clock (
      .clk   (clk),
      .rst_n (rst_n)
   );

   rtr_top UUT (
      .clk            (clk),
      .rst_n          (rst_n),
      .router_address (ADDR_W'(ROUTER_ADDR)),
      .flit_valid_in  (flit_valid_in),
      .flit_head_in   (flit_head_in),
      .flit_tail_in   (flit_tail_in),
      .flit_data_in   (flit_data_in),
      .credit_in      (credit_in),
      .flit_valid_out (flit_valid_out),
      .flit_head_out  (flit_head_out),
      .flit_tail_out  (flit_tail_out),
      .flit_data_out  (flit_data_out),
      .credit_out     (credit_out),
      .error          (error)
   );

   bind rtr_top rtr_sva u_sva (
      .clk            (clk),
      .rst_n          (rst_n),
      .flit_valid_in  (flit_valid_in),
      .flit_valid_out (flit_valid_out),
      .flit_head_out  (flit_head_out),
      .flit_tail_out  (flit_tail_out),
      .credit_out     (credit_out),
      .error          (error)
   );

   // --------------------
   // reporting
   // --------------------

   task automatic stop_run(string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
      assert (actual == expected)
      else
      begin
         stop_run($sformatf("Fail at %0t ns: %s expected %0h, got %0h",
                            $time, name, expected, actual));
      end
   endtask

   // --------------------
   // stimulus helpers
   // --------------------

   // dimension order on a line, from the routing rule
   function automatic logic [PORT_W-1:0] expected_port(int dest);
      if (dest < ROUTER_ADDR)
      begin
         return PORT_LEFT;
      end
      else if (dest > ROUTER_ADDR)
      begin
         return PORT_RIGHT;
      end
      return PORT_LOCAL;
   endfunction

   function automatic flit_data_u head_word(int dest);
      flit_data_u w;
      w.head.dest    = ADDR_W'(dest);
      w.head.payload = PAYLOAD_W'($random(seed));
      return w;
   endfunction

   function automatic logic [DATA_W-1:0] body_word();
      return DATA_W'($random(seed));
   endfunction

   // outputs settled after the rising edge, looked at on the falling one
   task automatic sample_outputs();
      credit_in = '0;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         if (flit_valid_out[p])
         begin
            rx_q.push_back({PORT_W'(p), flit_head_out[p], flit_tail_out[p], flit_data_out[p]});
            owed[p]++;
         end
         // downstream frees at most one slot per cycle
         if (!hold_credit[p] && owed[p] > 0)
         begin
            credit_in[p] = 1'b1;
            owed[p]--;
         end
         if (credit_out[p])
         begin
            tb_credit[p]++;
            returned[p]++;
         end
      end
      if (error)
      begin
         err_seen++;
         if (!err_allowed)
         begin
            check_value("error", 32'd0, 32'd1);
         end
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      @(negedge clk);
      sample_outputs();
      flit_valid_in = '0;
      flit_head_in  = '0;
      flit_tail_in  = '0;
   endtask

   task automatic drive_flit(int p, logic head, logic tail, logic [DATA_W-1:0] data);
      assert (tb_credit[p] > 0)
      else
      begin
         stop_run("testbench tried to send a flit without a credit");
      end
      flit_valid_in[p] = 1'b1;
      flit_head_in[p]  = head;
      flit_tail_in[p]  = tail;
      flit_data_in[p]  = data;
      tb_credit[p]--;
      accepted[p]++;
   endtask

   task automatic wait_credit(int p);
      int guard;
      guard = 0;
      while (tb_credit[p] == 0)
      begin
         next_cycle();
         guard++;
         assert (guard < TIMEOUT)
         else
         begin
            stop_run("timed out waiting for a credit_out pulse");
         end
      end
   endtask

   task automatic wait_rx(int n);
      int guard;
      guard = 0;
      while (rx_q.size() < n)
      begin
         next_cycle();
         guard++;
         assert (guard < TIMEOUT)
         else
         begin
            stop_run("timed out waiting for flits on the outputs");
         end
      end
   endtask

   task automatic expect_flit(logic [PORT_W-1:0] port, logic head, logic tail,
                              logic [DATA_W-1:0] data);
      logic [PORT_W+DATA_W+1:0] e;
      assert (rx_q.size() > 0)
      else
      begin
         stop_run("an output flit was expected but none arrived");
      end
      e = rx_q.pop_front();
      check_value("output port", 32'(port), 32'(e[PORT_W+DATA_W+1:DATA_W+2]));
      check_value("flit_head_out", 32'(head), 32'(e[DATA_W+1]));
      check_value("flit_tail_out", 32'(tail), 32'(e[DATA_W]));
      check_value("flit_data_out", 32'(data), 32'(e[DATA_W-1:0]));
   endtask

   task automatic check_packet(logic [PORT_W-1:0] port, logic [DATA_W-1:0] q [$]);
      for (int i = 0; i < q.size(); i++)
      begin
         expect_flit(port, i == 0, i == q.size() - 1, q[i]);
      end
   endtask

   // return all credits, then every accepted flit must have given one credit back
   task automatic settle();
      int   guard;
      logic busy;
      guard       = 0;
      busy        = 1'b1;
      hold_credit = '0;
      while (busy)
      begin
         busy = 1'b0;
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            if (returned[p] != accepted[p] || owed[p] != 0)
            begin
               busy = 1'b1;
            end
         end
         if (busy)
         begin
            next_cycle();
            guard++;
            assert (guard < TIMEOUT)
            else
            begin
               stop_run("timed out waiting for credits to come back");
            end
         end
      end
      repeat (3) next_cycle();
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         check_value("credit_out pulse count", 32'(accepted[p]), 32'(returned[p]));
      end
      check_value("unexpected output flits", 32'd0, 32'(rx_q.size()));
   endtask

   // --------------------
   // tests
   // --------------------

   task automatic test_routing();
      int         dests [3];
      int         dest;
      flit_data_u w;
      dests = '{0, 1, 3};
      for (int src = 0; src < NUM_PORTS; src++)
      begin
         for (int k = 0; k < 3; k++)
         begin
            dest = dests[k];
            w    = head_word(dest);
            drive_flit(src, 1'b1, 1'b1, w);
            // edge N takes it into the buffer
            next_cycle();
            check_value("flit_valid_out after edge N", 32'd0, 32'(rx_q.size()));
            // edge N+1 loads the output register
            next_cycle();
            check_value("flit_valid_out after edge N+1", 32'd1, 32'(rx_q.size()));
            expect_flit(expected_port(dest), 1'b1, 1'b1, w);
            rr_next[expected_port(dest)] = PORT_W'((src + 1) % NUM_PORTS);
         end
      end
      settle();
   endtask

   task automatic test_wormhole();
      logic [DATA_W-1:0] pkt_a [$];
      logic [DATA_W-1:0] pkt_b [$];
      logic              first_local;
      int                ia;
      int                ib;
      int                guard;
      pkt_a.push_back(head_word(3));
      pkt_b.push_back(head_word(3));
      for (int i = 1; i < LEN_A; i++)
      begin
         pkt_a.push_back(body_word());
      end
      for (int i = 1; i < LEN_B; i++)
      begin
         pkt_b.push_back(body_word());
      end
      // searching from the pointer meets local before left unless it starts at left
      first_local = (rr_next[PORT_RIGHT] != PORT_LEFT);
      ia    = 0;
      ib    = 0;
      guard = 0;
      // both heads go in on the same edge
      while (ia < LEN_A || ib < LEN_B)
      begin
         if (ia < LEN_A && tb_credit[PORT_LOCAL] > 0)
         begin
            drive_flit(PORT_LOCAL, ia == 0, ia == LEN_A - 1, pkt_a[ia]);
            ia++;
         end
         if (ib < LEN_B && tb_credit[PORT_LEFT] > 0)
         begin
            drive_flit(PORT_LEFT, ib == 0, ib == LEN_B - 1, pkt_b[ib]);
            ib++;
         end
         next_cycle();
         guard++;
         assert (guard < TIMEOUT)
         else
         begin
            stop_run("timed out sending the two wormhole packets");
         end
      end
      wait_rx(LEN_A + LEN_B);
      if (first_local)
      begin
         check_packet(PORT_RIGHT, pkt_a);
         check_packet(PORT_RIGHT, pkt_b);
      end
      else
      begin
         check_packet(PORT_RIGHT, pkt_b);
         check_packet(PORT_RIGHT, pkt_a);
      end
      settle();
   endtask

   // random destinations from all inputs at once, only counts matter here
   task automatic test_credit_return();
      int sent;
      sent = 0;
      for (int r = 0; r < RAND_ROUNDS; r++)
      begin
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            if (tb_credit[p] > 0)
            begin
               drive_flit(p, 1'b1, 1'b1, head_word($random(seed) & 3));
               sent++;
            end
         end
         next_cycle();
      end
      wait_rx(sent);
      check_value("flits delivered", 32'(sent), 32'(rx_q.size()));
      rx_q.delete();
      settle();
   endtask

   task automatic test_back_pressure();
      logic [DATA_W-1:0] pkt [$];
      pkt.push_back(head_word(3));
      for (int i = 1; i < BP_LEN; i++)
      begin
         pkt.push_back(body_word());
      end
      hold_credit[PORT_RIGHT] = 1'b1;
      for (int i = 0; i < BP_LEN; i++)
      begin
         wait_credit(PORT_LOCAL);
         drive_flit(PORT_LOCAL, i == 0, i == BP_LEN - 1, pkt[i]);
         next_cycle();
      end
      wait_rx(BUF_DEPTH);
      // out of credits, the output must stay quiet
      repeat (8) next_cycle();
      check_value("flits sent without credit_in", 32'(BUF_DEPTH), 32'(rx_q.size()));
      hold_credit[PORT_RIGHT] = 1'b0;
      wait_rx(BP_LEN);
      check_packet(PORT_RIGHT, pkt);
      settle();
   endtask

   task automatic test_error_report();
      logic [DATA_W-1:0] sent_q [$];
      flit_data_u        w;
      err_allowed            = 1'b1;
      err_seen               = 0;
      hold_credit[PORT_LOCAL] = 1'b1;
      // four leave and use up the local output, four more fill the right input buffer
      for (int i = 0; i < 2 * BUF_DEPTH; i++)
      begin
         wait_credit(PORT_RIGHT);
         w = head_word(ROUTER_ADDR);
         sent_q.push_back(w);
         drive_flit(PORT_RIGHT, 1'b1, 1'b1, w);
         next_cycle();
      end
      check_value("error pulses before overflow", 32'd0, 32'(err_seen));
      // one more into the full buffer, outside the credit rules
      flit_valid_in[PORT_RIGHT] = 1'b1;
      flit_head_in[PORT_RIGHT]  = 1'b1;
      flit_tail_in[PORT_RIGHT]  = 1'b1;
      flit_data_in[PORT_RIGHT]  = head_word(ROUTER_ADDR);
      next_cycle();
      check_value("error pulses after buffer overflow", 32'd1, 32'(err_seen));
      next_cycle();
      check_value("error pulses one cycle later", 32'd1, 32'(err_seen));
      hold_credit[PORT_LOCAL] = 1'b0;
      wait_rx(2 * BUF_DEPTH);
      check_value("flits delivered", 32'(2 * BUF_DEPTH), 32'(rx_q.size()));
      for (int i = 0; i < sent_q.size(); i++)
      begin
         expect_flit(PORT_LOCAL, 1'b1, 1'b1, sent_q[i]);
      end
      settle();
      // extra credit while the left counter is full
      credit_in[PORT_LEFT] = 1'b1;
      next_cycle();
      check_value("error pulses after credit overflow", 32'd2, 32'(err_seen));
      next_cycle();
      check_value("error pulses one cycle later", 32'd2, 32'(err_seen));
      err_allowed = 1'b0;
   endtask

   // --------------------
   // main sequence
   // --------------------

   initial
   begin
      int guard;
      seed          = 32'h64bc_c8a5;
      flit_valid_in = '0;
      flit_head_in  = '0;
      flit_tail_in  = '0;
      flit_data_in  = '0;
      credit_in     = '0;
      hold_credit   = '0;
      err_allowed   = 1'b0;
      err_seen      = 0;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         tb_credit[p] = BUF_DEPTH;
         accepted[p]  = 0;
         returned[p]  = 0;
         owed[p]      = 0;
         rr_next[p]   = PORT_LOCAL;
      end
      guard = 0;
      while (rst_n !== 1'b1)
      begin
         @(posedge clk);
         guard++;
         assert (guard < TIMEOUT)
         else
         begin
            stop_run("reset was never released");
         end
      end
      @(negedge clk);
      check_value("flit_valid_out after reset", 32'd0, 32'(flit_valid_out));
      check_value("credit_out after reset", 32'd0, 32'(credit_out));
      check_value("error after reset", 32'd0, 32'(error));

      test_routing();
      test_wormhole();
      test_credit_return();
      test_back_pressure();
      test_error_report();

      if (UUT.u_sva.fail_count == 0)
      begin
         $display("Done: no errors");
         $finish;
      end
      else
      begin
         stop_run("protocol assertions failed during the run");
      end
   end

endmodule

`default_nettype wire

/* files.f */
rtr_pkg.sv
rtr_input_buffer.sv
rtr_credit_counter.sv
rtr_switch_alloc.sv
rtr_top.sv
tb_clock.sv
rtr_sva.sv
rtr_tb.sv

/* Bender.yml */
package:
  name: rtr_line_router

sources:
  - rtr_pkg.sv
  - rtr_input_buffer.sv
  - rtr_credit_counter.sv
  - rtr_switch_alloc.sv
  - rtr_top.sv
  - target: simulation
    files:
      - tb_clock.sv
      - rtr_sva.sv
      - rtr_tb.sv
